// File: outrun_game.f
verilog/outrun_pkg.sv
verilog/outrun_cen.sv
verilog/outrun_vtimer.sv
verilog/outrun_dwnld.sv
verilog/outrun_slot.sv
verilog/outrun_bank_arb.sv
verilog/outrun_game.sv
testbench/outrun_game_tb.sv

// File: testbench/outrun_game_testdata.txt
# OutRun core test records, one per line, hex fields unless noted
# D byte_addr byte : ROM download byte, low byte first
# M addr expect / S addr expect : main or sub ROM read
# B main_addr main_expect sub_addr sub_expect : both ROM clients at once
# W addr data dsn : RAM write, dsn in binary, active low per byte
# R addr expect : RAM read
D 0000000 34
D 0000001 12
D 0000002 78
D 0000003 56
D 0080010 cd
D 0080011 ab
D 0080012 01
D 0080013 ef
M 00000 1234
S 00008 abcd
M 00001 5678
M 00001 5678
B 00000 1234 00009 ef01
S 00009 ef01
W 0010 beef 00
R 0010 beef
W 0010 1255 01
R 0010 12ef
W 0011 4321 00
W 0011 9988 10
R 0011 4388
R 0010 12ef

// File: testbench/outrun_game_tb.sv
/* OutRun core testbench */

module outrun_game_tb import outrun_pkg::*; ();

    localparam int WAIT_LIMIT  = 2000;
    localparam int LINE_LIMIT  = 20000;
    localparam int FRAME_LIMIT = 1000000;
    // wait conditions
    localparam int PROG_IDLE = 0;
    localparam int PROG_BUSY = 1;
    localparam int MAIN_OK   = 2;
    localparam int SUB_OK    = 3;
    localparam int RAM_OK    = 4;
    localparam int BOTH_OK   = 5;

    logic             clk;
    logic             arst_n;
    logic             downloading;
    logic [24:0]      ioctl_addr;
    logic [ 7:0]      ioctl_dout;
    logic             ioctl_wr;
    prog_t            prog;
    logic             prog_we;
    logic             prog_rdy;
    logic             dwnld_busy;
    logic             main_cs;
    logic             sub_cs;
    logic             ram_cs;
    main_addr_t       main_addr;
    sub_addr_t        sub_addr;
    ram_addr_t        ram_addr;
    logic             ram_rnw;
    logic [15:0]      ram_din;
    logic [ 1:0]      ram_dsn;
    logic             main_ok;
    logic             sub_ok;
    logic             ram_ok;
    logic [15:0]      main_data;
    logic [15:0]      sub_data;
    logic [15:0]      ram_data;
    logic [BA_AW-1:0] ba0_addr;
    logic             ba_rd;
    logic             ba_wr;
    logic [15:0]      ba0_din;
    logic [ 1:0]      ba0_din_m;
    logic             ba_ack;
    logic             ba_dok;
    logic             ba_rdy;
    logic [15:0]      data_read;
    logic             pxl2_cen;
    logic             pxl_cen;
    logic             LHBL;
    logic             LVBL;
    logic             HS;
    logic             VS;

    bit   [15:0]      sdram [0:(1<<BA_AW)-1];
    logic [BA_AW-1:0] rd_log [0:63];
    logic [17:0]      rom_last [0:1];
    logic             rom_valid [0:1];
    logic [ 7:0]      low_byte;
    int               rd_count;
    int               pix_count;
    int               errors;
    int               timeouts;
    integer           seed;

    outrun_game outrun_game_i (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic int rand_delay();
        logic [31:0] r;
        r = $random(seed);
        return 1 + int'(r[1:0]);
    endfunction

    // a set mask bit keeps the stored byte
    function automatic logic [15:0] masked_write(input logic [15:0] old_w,
                                                 input logic [15:0] new_w,
                                                 input logic [ 1:0] m);
        logic [15:0] w;
        w[15:8] = m[1] ? old_w[15:8] : new_w[15:8];
        w[ 7:0] = m[0] ? old_w[ 7:0] : new_w[ 7:0];
        return w;
    endfunction

    // SDRAM bank 0, one access at a time
    initial begin : bank_model
        int   d;
        logic is_rd;
        ba_ack    = 1'b0;
        ba_dok    = 1'b0;
        ba_rdy    = 1'b0;
        data_read = '0;
        forever begin
            @(negedge clk);
            if (ba_rd || ba_wr) begin
                is_rd = ba_rd;
                if (is_rd) begin
                    rd_log[rd_count % 64] = ba0_addr;
                    rd_count++;
                end
                d = rand_delay();
                repeat (d - 1) @(negedge clk);
                ba_ack = 1'b1;
                if (!is_rd) begin
                    sdram[ba0_addr] = masked_write(sdram[ba0_addr], ba0_din, ba0_din_m);
                end
                @(negedge clk);
                ba_ack = 1'b0;
                d = rand_delay();
                repeat (d - 1) @(negedge clk);
                data_read = sdram[ba0_addr];
                ba_dok    = is_rd;
                ba_rdy    = 1'b1;
                @(negedge clk);
                ba_dok = 1'b0;
                ba_rdy = 1'b0;
            end
        end
    end

    // programming port of the SDRAM controller
    initial begin : prog_model
        int d;
        prog_rdy = 1'b0;
        forever begin
            @(negedge clk);
            if (prog_we) begin
                d = rand_delay();
                repeat (d - 1) @(negedge clk);
                sdram[prog.addr] = masked_write(sdram[prog.addr], prog.data, prog.mask);
                prog_rdy = 1'b1;
                @(negedge clk);
                prog_rdy = 1'b0;
            end
        end
    end

    // pixel enables since reset give the position of the video counters
    initial begin : pixel_counter
        pix_count = 0;
        forever begin
            @(negedge clk);
            if (pxl_cen) begin
                pix_count++;
            end
        end
    end

    function automatic logic cond_met(input int which);
        case (which)
            PROG_IDLE: return !prog_we;
            PROG_BUSY: return prog_we;
            MAIN_OK:   return main_ok;
            SUB_OK:    return sub_ok;
            RAM_OK:    return ram_ok;
            default:   return main_ok && sub_ok;
        endcase
    endfunction

    task automatic wait_for(input int which, input string what);
        int n;
        n = 0;
        while (!cond_met(which) && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!cond_met(which)) begin
            $display("timeout while waiting for %s", what);
            timeouts++;
        end
    endtask

    task automatic check_word(input string name, input logic [21:0] exp, input logic [21:0] got);
        assert (got === exp) else begin
            $display("ERROR %s expected %h actual %h", name, exp, got);
            errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond) else begin
            $display("%s", what);
            errors++;
        end
    endtask

    task automatic send_byte(input logic [24:0] addr, input logic [7:0] b);
        wait_for(PROG_IDLE, "the pending programming word");
        ioctl_addr = addr;
        ioctl_dout = b;
        ioctl_wr   = 1'b1;
        @(negedge clk);
        ioctl_wr   = 1'b0;
        check_true(dwnld_busy, "dwnld_busy low during the download");
        if (!addr[0]) begin
            low_byte = b;
        end else begin
            wait_for(PROG_BUSY, "prog_we after an odd byte");
            check_word("prog addr", BA_AW'(addr >> 1), prog.addr);
            check_word("prog data", 16'(b) * 256 + 16'(low_byte), prog.data);
            check_word("prog mask", 22'd0, prog.mask);
        end
    endtask

    task automatic finish_download;
        wait_for(PROG_IDLE, "the last programming word");
        check_true(rd_count == 0, "ba_rd seen during the ROM download");
        main_cs     = 1'b0;
        downloading = 1'b0;
        @(negedge clk);
    endtask

    task automatic rom_read(input int client, input logic [17:0] addr, input logic [15:0] exp);
        int   mark;
        logic hit;
        mark = rd_count;
        hit  = rom_valid[client] && rom_last[client] == addr;
        if (client == 0) begin
            main_cs   = 1'b1;
            main_addr = addr;
        end else begin
            sub_cs   = 1'b1;
            sub_addr = addr[SUB_AW-1:0];
        end
        wait_for(client == 0 ? MAIN_OK : SUB_OK, "ok on a ROM read");
        repeat (2) @(negedge clk);
        check_true(client == 0 ? main_ok : sub_ok, "ok dropped with cs and address held");
        check_word($sformatf("%s read %h", client == 0 ? "main" : "sub", addr), exp,
                   client == 0 ? main_data : sub_data);
        if (hit) begin
            check_true(rd_count == mark, "repeated ROM read went to the SDRAM");
        end
        rom_valid[client] = 1'b1;
        rom_last[client]  = addr;
        main_cs = 1'b0;
        sub_cs  = 1'b0;
        @(negedge clk);
    endtask

    // main and sub raised in the same cycle
    task automatic both_read(input logic [17:0] ma, input logic [15:0] me,
                             input logic [17:0] sa, input logic [15:0] se);
        int mark;
        mark      = rd_count;
        main_cs   = 1'b1;
        main_addr = ma;
        sub_cs    = 1'b1;
        sub_addr  = sa[SUB_AW-1:0];
        wait_for(BOTH_OK, "ok on both ROM clients");
        check_word($sformatf("both main %h", ma), me, main_data);
        check_word($sformatf("both sub %h", sa), se, sub_data);
        check_word("first contended rd", MAIN_OFFSET + BA_AW'(ma), rd_log[mark % 64]);
        check_true(rd_count == mark + 2, "contention did not give two SDRAM reads");
        rom_valid[0] = 1'b1;
        rom_valid[1] = 1'b1;
        rom_last[0]  = ma;
        rom_last[1]  = sa;
        main_cs = 1'b0;
        sub_cs  = 1'b0;
        @(negedge clk);
    endtask

    // data is the write value, or the expected word on a read
    task automatic ram_access(input logic rnw, input logic [13:0] addr,
                              input logic [15:0] data, input logic [1:0] dsn);
        ram_cs   = 1'b1;
        ram_rnw  = rnw;
        ram_addr = addr;
        ram_din  = data;
        ram_dsn  = dsn;
        wait_for(RAM_OK, "ok on a RAM access");
        if (rnw) begin
            check_word($sformatf("ram read %h", addr), data, ram_data);
        end
        ram_cs = 1'b0;
        @(negedge clk);
    endtask

    // one line between two HS rising edges, counted in pixel enables
    task automatic check_video;
        int   n;
        int   edges;
        int   pulses;
        int   fast;
        int   hs_high;
        int   hb_low;
        logic hs_prev;
        n       = 0;
        edges   = 0;
        pulses  = 0;
        fast    = 0;
        hs_high = 0;
        hb_low  = 0;
        hs_prev = HS;
        while (edges < 2 && n < LINE_LIMIT) begin
            @(negedge clk);
            n++;
            if (HS && !hs_prev) begin
                edges++;
            end
            if (edges == 1 && pxl2_cen) begin
                fast++;
            end
            if (edges == 1 && pxl_cen) begin
                pulses++;
                hs_high += HS ? 1 : 0;
                hb_low  += LHBL ? 0 : 1;
            end
            hs_prev = HS;
        end
        if (edges < 2) begin
            $display("timeout while waiting for two HS rising edges");
            timeouts++;
        end else begin
            check_word("HS period", 22'(H_TOTAL), 22'(pulses));
            check_word("pxl2_cen per line", 22'(2 * H_TOTAL), 22'(fast));
            check_word("HS width", 22'(HS_END - HS_START), 22'(hs_high));
            check_word("LHBL low", 22'(H_TOTAL - HB_START + HB_END), 22'(hb_low));
        end
    endtask

    // vertical blanking end and sync start, placed by the pixel count
    task automatic check_frame;
        int n;
        n = 0;
        while (!LVBL && n < FRAME_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!LVBL) begin
            $display("timeout while waiting for LVBL to rise");
            timeouts++;
        end else begin
            check_word("LVBL rise", 22'(int'(VB_END) * int'(H_TOTAL)), 22'(pix_count));
        end
        n = 0;
        while (!VS && n < FRAME_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!VS) begin
            $display("timeout while waiting for VS to rise");
            timeouts++;
        end else begin
            check_word("VS rise", 22'(int'(VS_START) * int'(H_TOTAL)), 22'(pix_count));
            check_true(!LVBL, "LVBL high during vertical sync");
        end
    endtask

    initial begin : stimulus
        int                fd;
        int                n;
        int                k;
        logic [63:0]       tok;
        logic [24:0]       a;
        logic [24:0]       a2;
        logic [15:0]       d;
        logic [15:0]       d2;
        logic [ 1:0]       m;
        logic [8*128-1:0]  line;
        seed         = 32'h2f8;
        errors       = 0;
        timeouts     = 0;
        rd_count     = 0;
        rom_valid[0] = 1'b0;
        rom_valid[1] = 1'b0;
        arst_n       = 1'b0;
        downloading  = 1'b0;
        ioctl_addr   = '0;
        ioctl_dout   = '0;
        ioctl_wr     = 1'b0;
        main_cs      = 1'b0;
        main_addr    = '0;
        sub_cs       = 1'b0;
        sub_addr     = '0;
        ram_cs       = 1'b0;
        ram_addr     = '0;
        ram_rnw      = 1'b1;
        ram_din      = '0;
        ram_dsn      = 2'b11;
        repeat (10) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        fd = $fopen("testbench/outrun_game_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open the test data file");
            errors++;
        end else begin
            n = $fscanf(fd, "%s", tok);
            while (n == 1) begin
                if (tok == "#") begin
                    k = $fgets(line, fd);
                end else if (tok == "D") begin
                    k = $fscanf(fd, "%h %h", a, d);
                    if (!downloading) begin
                        downloading = 1'b1;
                        // main read held off until the download ends
                        main_cs     = 1'b1;
                        main_addr   = '0;
                        @(negedge clk);
                    end
                    send_byte(a, d[7:0]);
                end else begin
                    if (downloading) begin
                        finish_download();
                    end
                    case (tok)
                        "M": begin
                            k = $fscanf(fd, "%h %h", a, d);
                            rom_read(0, a[17:0], d);
                        end
                        "S": begin
                            k = $fscanf(fd, "%h %h", a, d);
                            rom_read(1, a[17:0], d);
                        end
                        "B": begin
                            k = $fscanf(fd, "%h %h %h %h", a, d, a2, d2);
                            both_read(a[17:0], d, a2[17:0], d2);
                        end
                        "W": begin
                            k = $fscanf(fd, "%h %h %b", a, d, m);
                            ram_access(1'b0, a[13:0], d, m);
                        end
                        "R": begin
                            k = $fscanf(fd, "%h %h", a, d);
                            ram_access(1'b1, a[13:0], d, 2'b00);
                        end
                        default: check_true(1'b0, "unknown record kind in the test data");
                    endcase
                end
                n = $fscanf(fd, "%s", tok);
            end
            $fclose(fd);
        end
        check_video();
        check_frame();
        $display("checks finished with %0d errors and %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: verilog/outrun_game.sv
/* OutRun game core top level */

module outrun_game import outrun_pkg::*; (
    input  logic             clk,
    input  logic             arst_n,
    // ROM download
    input  logic             downloading,
    input  logic [24:0]      ioctl_addr,
    input  logic [ 7:0]      ioctl_dout,
    input  logic             ioctl_wr,
    output prog_t            prog,
    output logic             prog_we,
    input  logic             prog_rdy,
    output logic             dwnld_busy,
    // CPU side clients
    input  logic             main_cs,
    input  main_addr_t       main_addr,
    output logic             main_ok,
    output logic [15:0]      main_data,
    input  logic             sub_cs,
    input  sub_addr_t        sub_addr,
    output logic             sub_ok,
    output logic [15:0]      sub_data,
    input  logic             ram_cs,
    input  ram_addr_t        ram_addr,
    input  logic             ram_rnw,
    input  logic [15:0]      ram_din,
    input  logic [ 1:0]      ram_dsn,
    output logic             ram_ok,
    output logic [15:0]      ram_data,
    // bank 0
    output logic [BA_AW-1:0] ba0_addr,
    output logic             ba_rd,
    output logic             ba_wr,
    output logic [15:0]      ba0_din,
    output logic [ 1:0]      ba0_din_m,
    input  logic             ba_ack,
    input  logic             ba_dok,
    input  logic             ba_rdy,
    input  logic [15:0]      data_read,
    // video
    output logic             pxl2_cen,
    output logic             pxl_cen,
    output logic             LHBL,
    output logic             LVBL,
    output logic             HS,
    output logic             VS
);

    logic [N_SLOTS-1:0]    slot_req;
    logic [N_SLOTS-1:0]    slot_grant;
    logic [N_SLOTS-1:0]    slot_done;
    ba_req_t [N_SLOTS-1:0] slot_breq;
    logic [15:0]           slot_rdata;

    outrun_cen u_cen (
        .clk      ( clk      ),
        .arst_n   ( arst_n   ),
        .pxl2_cen ( pxl2_cen ),
        .pxl_cen  ( pxl_cen  )
    );

    // vrender only feeds the absent graphics side
    outrun_vtimer u_timer (
        .clk     ( clk     ),
        .arst_n  ( arst_n  ),
        .pxl_cen ( pxl_cen ),
        .LHBL    ( LHBL    ),
        .LVBL    ( LVBL    ),
        .HS      ( HS      ),
        .VS      ( VS      ),
        .vrender (         )
    );

    outrun_dwnld u_dwnld (
        .clk         ( clk         ),
        .arst_n      ( arst_n      ),
        .downloading ( downloading ),
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_dout  ( ioctl_dout  ),
        .ioctl_wr    ( ioctl_wr    ),
        .prog        ( prog        ),
        .prog_we     ( prog_we     ),
        .prog_rdy    ( prog_rdy    ),
        .dwnld_busy  ( dwnld_busy  )
    );

    // ROM slots are read only
    outrun_slot #(.addr_t(main_addr_t), .OFFSET(MAIN_OFFSET)) u_main_slot (
        .clk    ( clk           ),
        .arst_n ( arst_n        ),
        .cs     ( main_cs       ),
        .addr   ( main_addr     ),
        .rnw    ( 1'b1          ),
        .din    ( 16'h0000      ),
        .dsn    ( 2'b11         ),
        .ok     ( main_ok       ),
        .dout   ( main_data     ),
        .req    ( slot_req[0]   ),
        .breq   ( slot_breq[0]  ),
        .grant  ( slot_grant[0] ),
        .done   ( slot_done[0]  ),
        .rdata  ( slot_rdata    )
    );

    outrun_slot #(.addr_t(sub_addr_t), .OFFSET(SUB_OFFSET)) u_sub_slot (
        .clk    ( clk           ),
        .arst_n ( arst_n        ),
        .cs     ( sub_cs        ),
        .addr   ( sub_addr      ),
        .rnw    ( 1'b1          ),
        .din    ( 16'h0000      ),
        .dsn    ( 2'b11         ),
        .ok     ( sub_ok        ),
        .dout   ( sub_data      ),
        .req    ( slot_req[1]   ),
        .breq   ( slot_breq[1]  ),
        .grant  ( slot_grant[1] ),
        .done   ( slot_done[1]  ),
        .rdata  ( slot_rdata    )
    );

    outrun_slot #(.addr_t(ram_addr_t), .OFFSET(RAM_OFFSET)) u_ram_slot (
        .clk    ( clk           ),
        .arst_n ( arst_n        ),
        .cs     ( ram_cs        ),
        .addr   ( ram_addr      ),
        .rnw    ( ram_rnw       ),
        .din    ( ram_din       ),
        .dsn    ( ram_dsn       ),
        .ok     ( ram_ok        ),
        .dout   ( ram_data      ),
        .req    ( slot_req[2]   ),
        .breq   ( slot_breq[2]  ),
        .grant  ( slot_grant[2] ),
        .done   ( slot_done[2]  ),
        .rdata  ( slot_rdata    )
    );

    outrun_bank_arb u_arb (
        .clk         ( clk         ),
        .arst_n      ( arst_n      ),
        .downloading ( downloading ),
        .req         ( slot_req    ),
        .breq        ( slot_breq   ),
        .grant       ( slot_grant  ),
        .done        ( slot_done   ),
        .rdata       ( slot_rdata  ),
        .ba0_addr    ( ba0_addr    ),
        .ba_rd       ( ba_rd       ),
        .ba_wr       ( ba_wr       ),
        .ba0_din     ( ba0_din     ),
        .ba0_din_m   ( ba0_din_m   ),
        .ba_ack      ( ba_ack      ),
        .ba_dok      ( ba_dok      ),
        .ba_rdy      ( ba_rdy      ),
        .data_read   ( data_read   )
    );

endmodule

// File: verilog/outrun_bank_arb.sv
/* Bank 0 arbiter */

module outrun_bank_arb import outrun_pkg::*; (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  downloading,
    input  logic [N_SLOTS-1:0]    req,
    input  ba_req_t [N_SLOTS-1:0] breq,
    output logic [N_SLOTS-1:0]    grant,
    output logic [N_SLOTS-1:0]    done,
    output logic [15:0]           rdata,
    output logic [BA_AW-1:0]      ba0_addr,
    output logic                  ba_rd,
    output logic                  ba_wr,
    output logic [15:0]           ba0_din,
    output logic [ 1:0]           ba0_din_m,
    input  logic                  ba_ack,
    input  logic                  ba_dok,
    input  logic                  ba_rdy,
    input  logic [15:0]           data_read
);

    typedef enum logic [1:0] {
        IDLE,
        WAIT_ACK,
        WAIT_RDY
    } state_t;

    state_t             state;
    logic [SEL_W-1:0]   sel;
    logic [SEL_W-1:0]   winner;
    logic [N_SLOTS-1:0] pending;
    logic               start;

    // a finished slot still shows req while its done is out
    assign pending = req & ~done;

    // lowest index wins, main first
    always_comb begin
        winner = '0;
        for (int i = N_SLOTS - 1; i >= 0; i--) begin
            if (pending[i]) begin
                winner = SEL_W'(i);
            end
        end
    end

    assign start = state == IDLE && !downloading && |pending;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
            sel   <= '0;
            grant <= '0;
            done  <= '0;
            ba_rd <= 1'b0;
            ba_wr <= 1'b0;
        end else begin
            grant <= '0;
            done  <= '0;
            case (state)
                IDLE: if (start) begin
                    sel           <= winner;
                    grant[winner] <= 1'b1;
                    ba_rd         <= !breq[winner].wr;
                    ba_wr         <= breq[winner].wr;
                    state         <= WAIT_ACK;
                end
                WAIT_ACK: if (ba_ack) begin
                    ba_rd <= 1'b0;
                    ba_wr <= 1'b0;
                    // short accesses may finish with the ack
                    if (ba_rdy) begin
                        done[sel] <= 1'b1;
                        state     <= IDLE;
                    end else begin
                        state     <= WAIT_RDY;
                    end
                end
                WAIT_RDY: if (ba_rdy) begin
                    done[sel] <= 1'b1;
                    state     <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            ba0_addr  <= breq[winner].addr;
            ba0_din   <= breq[winner].din;
            ba0_din_m <= breq[winner].din_m;
        end
        if (ba_dok) begin
            rdata <= data_read;
        end
    end

    a_rd_wr_excl: assert property (
        @(posedge clk) disable iff (!arst_n) !(ba_rd && ba_wr)
    );

endmodule

// File: verilog/outrun_slot.sv
/* SDRAM client slot */

module outrun_slot import outrun_pkg::*; #(
    parameter type              addr_t = main_addr_t,
    parameter logic [BA_AW-1:0] OFFSET = '0
) (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        cs,
    input  addr_t       addr,
    input  logic        rnw,
    input  logic [15:0] din,
    input  logic [ 1:0] dsn,
    output logic        ok,
    output logic [15:0] dout,
    output logic        req,
    output ba_req_t     breq,
    input  logic        grant,
    input  logic        done,
    input  logic [15:0] rdata
);

    logic [BA_AW-1:0] full_addr;
    logic [BA_AW-1:0] last_addr;
    logic [15:0]      last_data;
    logic             valid;
    logic             wr_hit;
    logic             granted;
    logic             same_addr;
    logic             served;
    logic             issue;

    // byte merge, a low mask bit selects the new byte
    function automatic logic [15:0] merge(
        input logic [15:0] old_w,
        input logic [15:0] new_w,
        input logic [ 1:0] m
    );
        merge[15:8] = m[1] ? old_w[15:8] : new_w[15:8];
        merge[ 7:0] = m[0] ? old_w[ 7:0] : new_w[ 7:0];
    endfunction

    assign full_addr = BA_AW'(addr) + OFFSET;
    assign same_addr = last_addr == full_addr;
    assign served    = rnw ? (valid && same_addr) : (wr_hit && same_addr);
    assign issue     = cs && !req && !served;
    assign dout      = last_data;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ok      <= 1'b0;
            req     <= 1'b0;
            granted <= 1'b0;
            valid   <= 1'b0;
            wr_hit  <= 1'b0;
        end else begin
            ok <= cs && served && !req;
            if (issue) begin
                req    <= 1'b1;
                wr_hit <= 1'b0;
            end
            if (grant) begin
                granted <= 1'b1;
            end
            if (done) begin
                req     <= 1'b0;
                granted <= 1'b0;
                if (breq.wr) begin
                    wr_hit <= 1'b1;
                    // partial write to an uncached word leaves it unknown
                    valid  <= (valid && last_addr == breq.addr) || breq.din_m == 2'b00;
                end else begin
                    valid  <= 1'b1;
                end
            end
            if (!cs) begin
                wr_hit <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            breq.addr  <= full_addr;
            breq.wr    <= !rnw;
            breq.din   <= din;
            breq.din_m <= rnw ? 2'b11 : dsn;
        end
        if (done) begin
            last_addr <= breq.addr;
            last_data <= breq.wr ? merge(last_data, breq.din, breq.din_m) : rdata;
        end
    end

    a_done_owned: assert property (
        @(posedge clk) disable iff (!arst_n) done |-> req && granted
    );

endmodule

// File: verilog/outrun_dwnld.sv
/* ROM download packer */

module outrun_dwnld import outrun_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        downloading,
    input  logic [24:0] ioctl_addr,
    input  logic [ 7:0] ioctl_dout,
    input  logic        ioctl_wr,
    output prog_t       prog,
    output logic        prog_we,
    input  logic        prog_rdy,
    output logic        dwnld_busy
);

    logic [7:0] low_byte;
    logic       take;

    // bytes are only taken with no word pending
    assign take       = downloading && ioctl_wr && !prog_we;
    assign dwnld_busy = downloading || prog_we;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            prog_we <= 1'b0;
        end else if (take && ioctl_addr[0]) begin
            prog_we <= 1'b1;
        end else if (prog_rdy) begin
            prog_we <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take && !ioctl_addr[0]) begin
            low_byte <= ioctl_dout;
        end
        // odd byte completes the word
        if (take && ioctl_addr[0]) begin
            prog <= '{
                addr: ioctl_addr[BA_AW:1],
                data: {ioctl_dout, low_byte},
                mask: 2'b00
            };
        end
    end

    a_no_byte_pending: assert property (
        @(posedge clk) disable iff (!arst_n)
        downloading && ioctl_wr |-> !prog_we
    );

endmodule

// File: verilog/outrun_vtimer.sv
/* Video timer */

module outrun_vtimer import outrun_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       pxl_cen,
    output logic       LHBL,
    output logic       LVBL,
    output logic       HS,
    output logic       VS,
    output logic [8:0] vrender
);

    logic [8:0] h_cnt;
    logic [8:0] v_cnt;
    logic [8:0] h_nxt;
    logic [8:0] v_nxt;
    logic       h_last;
    logic       v_last;

    assign h_last = h_cnt == 9'(H_TOTAL - 10'd1);
    assign v_last = v_cnt == V_TOTAL - 9'd1;

    always_comb begin
        h_nxt = h_last ? 9'd0 : h_cnt + 9'd1;
        v_nxt = v_cnt;
        // line advances at the horizontal wrap
        if (h_last) begin
            v_nxt = v_last ? 9'd0 : v_cnt + 9'd1;
        end
    end

    // line the SDRAM side prepares next
    assign vrender = v_last ? 9'd0 : v_cnt + 9'd1;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            h_cnt <= '0;
            v_cnt <= '0;
            LHBL  <= 1'b0;
            LVBL  <= 1'b0;
            HS    <= 1'b0;
            VS    <= 1'b0;
        end else if (pxl_cen) begin
            h_cnt <= h_nxt;
            v_cnt <= v_nxt;
            // decode on the new count so outputs track the counters
            LHBL  <= !(h_nxt >= HB_START || h_nxt < HB_END);
            HS    <= h_nxt >= HS_START && h_nxt < HS_END;
            LVBL  <= !(v_nxt >= VB_START || v_nxt < VB_END);
            VS    <= v_nxt >= VS_START && v_nxt < VS_END;
        end
    end

    a_h_range: assert property (
        @(posedge clk) disable iff (!arst_n) h_cnt <= 9'(H_TOTAL - 10'd1)
    );

endmodule

// File: verilog/outrun_cen.sv
/* Pixel clock enables */

module outrun_cen import outrun_pkg::*; (
    input  logic clk,
    input  logic arst_n,
    output logic pxl2_cen,
    output logic pxl_cen
);

    logic [CEN_W-1:0] cnt;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt      <= '0;
            pxl2_cen <= 1'b0;
            pxl_cen  <= 1'b0;
        end else begin
            cnt      <= cnt + 1'b1;
            // every 4th and every 8th clk
            pxl2_cen <= &cnt[1:0];
            pxl_cen  <= &cnt;
        end
    end

    // the slow enable must line up with the fast one
    a_cen_nested: assert property (
        @(posedge clk) disable iff (!arst_n) pxl_cen |-> pxl2_cen
    );

endmodule

// File: verilog/outrun_pkg.sv
/* OutRun memory and video core
   shared constants and types */

package outrun_pkg;

    // video timing, 512 pixels by 262 lines
    localparam logic [8:0] HB_START = 9'd416;
    localparam logic [8:0] HB_END   = 9'd96;
    localparam logic [8:0] HS_START = 9'd440;
    localparam logic [8:0] HS_END   = 9'd472;
    // one bit wider, 512 does not fit in nine
    localparam logic [9:0] H_TOTAL  = 10'd512;
    localparam logic [8:0] VB_START = 9'd224;
    localparam logic [8:0] VB_END   = 9'd16;
    localparam logic [8:0] VS_START = 9'd240;
    localparam logic [8:0] VS_END   = 9'd243;
    localparam logic [8:0] V_TOTAL  = 9'd262;

    // pixel clock divider width
    localparam int CEN_W = 3;

    // address widths in 16-bit words
    localparam int BA_AW   = 22;
    localparam int MAIN_AW = 18;
    localparam int SUB_AW  = 17;
    localparam int RAM_AW  = 14;

    // bank 0 layout
    localparam logic [BA_AW-1:0] MAIN_OFFSET = 22'h00000;
    localparam logic [BA_AW-1:0] SUB_OFFSET  = 22'h40000;
    localparam logic [BA_AW-1:0] RAM_OFFSET  = 22'h60000;

    localparam int N_SLOTS = 3;
    localparam int SEL_W   = $clog2(N_SLOTS);

    typedef logic [MAIN_AW-1:0] main_addr_t;
    typedef logic [SUB_AW-1:0]  sub_addr_t;
    typedef logic [RAM_AW-1:0]  ram_addr_t;

    // din_m is active low per byte
    typedef struct packed {
        logic [BA_AW-1:0] addr;
        logic             wr;
        logic [15:0]      din;
        logic [1:0]       din_m;
    } ba_req_t;

    typedef struct packed {
        logic [BA_AW-1:0] addr;
        logic [15:0]      data;
        logic [1:0]       mask;
    } prog_t;

endpackage
